// ==== Makefile ====
# Verilator build and run for turf_ctrl

SIM      ?= verilator
TOP      ?= turf_ctrl_tb
FILELIST ?= turf_ctrl.f
OBJ_DIR  ?= obj_dir
VFLAGS   ?= --binary --timing --assert -Wno-fatal
PASS_MSG ?= PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(SIM) and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== source/baud_tick_gen.sv ====
`timescale 1ns/100ps

module baud_tick_gen #(
    parameter int unsigned ADD  = 82,
    parameter int unsigned BITS = 10
) (
    input  logic ps_clk,
    input  logic rst_n_i,
    output logic tick_o
);

    // Increment with room for the carry
    localparam logic [BITS:0] ADD_W = (BITS + 1)'(ADD);

    // Phase accumulator
    logic [BITS-1:0] acc_q;
    logic [BITS:0]   acc_sum;
    logic            tick_q;

    // Carry out is the tick
    assign acc_sum = {1'b0, acc_q} + ADD_W;

    always_ff @(posedge ps_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            acc_q  <= '0;
            tick_q <= 1'b0;
        end else begin
            acc_q  <= acc_sum[BITS-1:0];
            tick_q <= acc_sum[BITS];
        end
    end

    assign tick_o = tick_q;

    ////////////////////////////////////////////////
    // Tick width check
    ////////////////////////////////////////////////

    // Below half rate two carries cannot be back to back
    generate
        if (ADD < (1 << (BITS - 1))) begin : g_tick_chk
            single_tick: assert property (
                @(posedge ps_clk) disable iff (!rst_n_i)
                tick_o |=> !tick_o
            ) else $error("baud tick longer than one cycle");
        end
    endgenerate

endmodule

// ==== source/bridge_check.sv ====
`timescale 1ns/100ps
`include "turf_defs.svh"

module bridge_check import turf_pkg::*; (
    input  logic        ps_clk,
    input  logic        rst_n_i,
    input  logic        crate_stb_i,
    input  link_idx_t   crate_link_i,
    input  bridge_sel_t bridge_sel_i,
    input  link_mask_t  aurora_up_i,
    input  link_mask_t  invalid_clr_i,
    output logic        crate_fwd_o,
    output link_idx_t   crate_fwd_link_o,
    output link_mask_t  invalid_o
);

    // Per-link validity table
    link_mask_t link_ok;
    logic       access_ok;
    link_mask_t invalid_set;
    // Forward and sticky state
    logic       fwd_q;
    link_idx_t  fwd_link_q;
    link_mask_t invalid_q;

    // Reserved types are never valid
    function automatic logic type_ok(input bridge_type_e btype, input logic up);
        logic ok;
        case (btype)
            BRIDGE_NONE:   ok = 1'b1;
            BRIDGE_AURORA: ok = up;
            BRIDGE_RSVD2:  ok = 1'b0;
            BRIDGE_RSVD3:  ok = 1'b0;
            default:       ok = 1'b0;
        endcase
        return ok;
    endfunction

    always_comb begin
        for (int n = 0; n < `TURF_NUM_LINKS; n++) begin
            link_ok[n] = type_ok(bridge_type_e'(bridge_sel_i[2*n +: 2]), aurora_up_i[n]);
        end
    end

    assign access_ok = link_ok[crate_link_i];

    // Refused strobe marks its own link
    always_comb begin
        invalid_set = '0;
        if (crate_stb_i && !access_ok) begin
            invalid_set[crate_link_i] = 1'b1;
        end
    end

    always_ff @(posedge ps_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fwd_q     <= 1'b0;
            invalid_q <= '0;
        end else begin
            fwd_q     <= crate_stb_i & access_ok;
            // Set wins over a same-cycle clear
            invalid_q <= (invalid_q & ~invalid_clr_i) | invalid_set;
        end
    end

    // Link number rides along with the strobe
    always_ff @(posedge ps_clk) begin
        if (crate_stb_i) begin
            fwd_link_q <= crate_link_i;
        end
    end

    assign crate_fwd_o      = fwd_q;
    assign crate_fwd_link_o = fwd_link_q;
    assign invalid_o        = invalid_q;

    // A forwarded strobe never raises a flag too
    fwd_or_flag: assert property (
        @(posedge ps_clk) disable iff (!rst_n_i)
        crate_fwd_o |-> ((invalid_o & ~$past(invalid_o)) == '0)
    ) else $error("crate strobe both forwarded and flagged");

endmodule

// ==== source/i2c_merger.sv ====
`timescale 1ns/100ps

module i2c_merger (
    input  logic ps_clk,
    input  logic rst_n_i,
    input  logic ps_scl_i,
    input  logic ps_sda_t_i,
    input  logic clk_sda_i,
    input  logic cal_sda_i,
    output logic clk_scl_o,
    output logic cal_scl_o,
    output logic clk_sda_oe_o,
    output logic cal_sda_oe_o,
    output logic ps_sda_o
);

    // Wired-AND of both buses
    logic sda_merged;
    // Two-flop synchronizer
    logic sda_meta_q;
    logic sda_sync_q;

    // SCL fans straight out
    assign clk_scl_o = ps_scl_i;
    assign cal_scl_o = ps_scl_i;

    // PS tristate high means released
    assign clk_sda_oe_o = ~ps_sda_t_i;
    assign cal_sda_oe_o = ~ps_sda_t_i;

    assign sda_merged = clk_sda_i & cal_sda_i;

    // Idle bus reads high
    always_ff @(posedge ps_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sda_meta_q <= 1'b1;
            sda_sync_q <= 1'b1;
        end else begin
            sda_meta_q <= sda_merged;
            sda_sync_q <= sda_meta_q;
        end
    end

    assign ps_sda_o = sda_sync_q;

endmodule

// ==== source/turf_ctrl_top.sv ====
`timescale 1ns/100ps
`include "turf_defs.svh"

module turf_ctrl_top import turf_pkg::*; (
    input  logic       ps_clk,
    input  logic       rst_n_i,
    // Register port
    input  logic       wb_cyc_i,
    input  logic       wb_stb_i,
    input  logic       wb_we_i,
    input  reg_addr_t  wb_adr_i,
    input  reg_data_t  wb_dat_i,
    output logic       wb_ack_o,
    output reg_data_t  wb_dat_o,
    // Aurora link state and crate access
    input  link_mask_t aurora_up_i,
    input  logic       crate_stb_i,
    input  link_idx_t  crate_link_i,
    output logic       crate_fwd_o,
    output link_idx_t  crate_fwd_link_o,
    // PS I2C master and the two boards
    input  logic       ps_scl_i,
    input  logic       ps_sda_t_i,
    output logic       ps_sda_o,
    output logic       clk_scl_o,
    output logic       clk_sda_oe_o,
    input  logic       clk_sda_i,
    output logic       cal_scl_o,
    output logic       cal_sda_oe_o,
    input  logic       cal_sda_i,
    // Debug capture ticks
    output logic       hsk_tick_o,
    output logic       gps_tick_o
);

    bridge_sel_t bridge_sel;
    link_mask_t  invalid;
    link_mask_t  invalid_clr;

    //////////////////////////////////////////////////
    // Registers and crate bridge
    //////////////////////////////////////////////////

    turf_regfile u_regfile (
        .ps_clk        (ps_clk),
        .rst_n_i       (rst_n_i),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_we_i       (wb_we_i),
        .wb_adr_i      (wb_adr_i),
        .wb_dat_i      (wb_dat_i),
        .invalid_i     (invalid),
        .aurora_up_i   (aurora_up_i),
        .wb_ack_o      (wb_ack_o),
        .wb_dat_o      (wb_dat_o),
        .bridge_sel_o  (bridge_sel),
        .invalid_clr_o (invalid_clr)
    );

    bridge_check u_bridge (
        .ps_clk           (ps_clk),
        .rst_n_i          (rst_n_i),
        .crate_stb_i      (crate_stb_i),
        .crate_link_i     (crate_link_i),
        .bridge_sel_i     (bridge_sel),
        .aurora_up_i      (aurora_up_i),
        .invalid_clr_i    (invalid_clr),
        .crate_fwd_o      (crate_fwd_o),
        .crate_fwd_link_o (crate_fwd_link_o),
        .invalid_o        (invalid)
    );

    //////////////////////////////////////////////////
    // I2C and baud ticks
    //////////////////////////////////////////////////

    i2c_merger u_i2c (
        .ps_clk       (ps_clk),
        .rst_n_i      (rst_n_i),
        .ps_scl_i     (ps_scl_i),
        .ps_sda_t_i   (ps_sda_t_i),
        .clk_sda_i    (clk_sda_i),
        .cal_sda_i    (cal_sda_i),
        .clk_scl_o    (clk_scl_o),
        .cal_scl_o    (cal_scl_o),
        .clk_sda_oe_o (clk_sda_oe_o),
        .cal_sda_oe_o (cal_sda_oe_o),
        .ps_sda_o     (ps_sda_o)
    );

    // 82 in 1024 gives 8 MHz from 100 MHz
    baud_tick_gen #(.ADD(`HSK_BAUD_ADD), .BITS(`HSK_BAUD_BITS)) u_hsk_baud (
        .ps_clk  (ps_clk),
        .rst_n_i (rst_n_i),
        .tick_o  (hsk_tick_o)
    );

    baud_tick_gen #(.ADD(`GPS_BAUD_ADD), .BITS(`GPS_BAUD_BITS)) u_gps_baud (
        .ps_clk  (ps_clk),
        .rst_n_i (rst_n_i),
        .tick_o  (gps_tick_o)
    );

endmodule

// ==== source/turf_defs.svh ====
`ifndef TURF_DEFS_SVH
`define TURF_DEFS_SVH

//////////////////////////////////////////////////
// Identity and version
//////////////////////////////////////////////////

// ASCII "TURF"
`define TURF_IDENT        32'h54555246

`define TURF_VER_MAJOR    4'd0
`define TURF_VER_MINOR    4'd3
`define TURF_VER_REV      8'd0
`define TURF_FW_DATE      16'h1234
// Set for revision B boards
`define TURF_REV_B        1'b0

// Rev-B flag, low 15 date bits, then major/minor/rev
`define TURF_DATEVERSION  ((32'(`TURF_REV_B) << 31) | \
                           ((32'(`TURF_FW_DATE) & 32'h7fff) << 16) | \
                           (32'(`TURF_VER_MAJOR) << 12) | \
                           (32'(`TURF_VER_MINOR) << 8) | \
                           32'(`TURF_VER_REV))

//////////////////////////////////////////////////
// Register word addresses
//////////////////////////////////////////////////

`define REG_ADDR_IDENT    0
`define REG_ADDR_DATEVER  1
`define REG_ADDR_BRIDGE   2
`define REG_ADDR_INVALID  3
`define REG_ADDR_LINKUP   4

// Aurora links to the TURFIOs
`define TURF_NUM_LINKS    4

// Housekeeping 16x tick, 8 MHz from 100 MHz
`define HSK_BAUD_ADD      82
`define HSK_BAUD_BITS     10
// GPS 16x tick at 38400 baud
`define GPS_BAUD_ADD      25
`define GPS_BAUD_BITS     12

`endif

// ==== source/turf_pkg.sv ====
`include "turf_defs.svh"

package turf_pkg;

    //////////////////////////////////////////////////
    // Register port types
    //////////////////////////////////////////////////

    // Word address on the register port
    typedef logic [3:0]  reg_addr_t;
    // Register data word
    typedef logic [31:0] reg_data_t;

    //////////////////////////////////////////////////
    // Link types
    //////////////////////////////////////////////////

    // Link number
    typedef logic [1:0]                   link_idx_t;
    // One bit per link
    typedef logic [`TURF_NUM_LINKS-1:0]   link_mask_t;
    // Two bits per link, link n at 2n+1:2n
    typedef logic [2*`TURF_NUM_LINKS-1:0] bridge_sel_t;

    // Crate bridge types
    typedef enum logic [1:0] {
        BRIDGE_NONE   = 2'd0,
        BRIDGE_AURORA = 2'd1,
        BRIDGE_RSVD2  = 2'd2,
        BRIDGE_RSVD3  = 2'd3
    } bridge_type_e;

endpackage

// ==== source/turf_regfile.sv ====
`timescale 1ns/100ps
`include "turf_defs.svh"

module turf_regfile import turf_pkg::*; (
    input  logic        ps_clk,
    input  logic        rst_n_i,
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  reg_addr_t   wb_adr_i,
    input  reg_data_t   wb_dat_i,
    input  link_mask_t  invalid_i,
    input  link_mask_t  aurora_up_i,
    output logic        wb_ack_o,
    output reg_data_t   wb_dat_o,
    output bridge_sel_t bridge_sel_o,
    output link_mask_t  invalid_clr_o
);

    // Request qualifiers
    logic        wb_req;
    logic        wb_access;
    logic        wb_write;
    // Read mux output
    reg_data_t   rd_data;
    // Ack and register state
    logic        ack_q;
    bridge_sel_t bridge_sel_q;
    link_mask_t  clr_q;
    reg_data_t   dat_q;

    //////////////////////////////////////////////////
    // Request decode
    //////////////////////////////////////////////////

    // Request is cyc and stb together
    assign wb_req    = wb_cyc_i & wb_stb_i;
    // First cycle of a request only
    assign wb_access = wb_req & ~ack_q;
    assign wb_write  = wb_access & wb_we_i;

    // Read mux
    always_comb begin
        case (wb_adr_i)
            `REG_ADDR_IDENT:   rd_data = `TURF_IDENT;
            `REG_ADDR_DATEVER: rd_data = `TURF_DATEVERSION;
            `REG_ADDR_BRIDGE:  rd_data = reg_data_t'(bridge_sel_q);
            `REG_ADDR_INVALID: rd_data = reg_data_t'(invalid_i);
            `REG_ADDR_LINKUP:  rd_data = reg_data_t'(aurora_up_i);
            default:           rd_data = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Ack and control registers
    //////////////////////////////////////////////////

    always_ff @(posedge ps_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q        <= 1'b0;
            bridge_sel_q <= '0;
            clr_q        <= '0;
        end else begin
            // One-cycle ack pulse
            ack_q <= wb_access;
            if (wb_write && wb_adr_i == reg_addr_t'(`REG_ADDR_BRIDGE)) begin
                bridge_sel_q <= bridge_sel_t'(wb_dat_i);
            end
            // Write-one-to-clear pulse for the sticky flags
            if (wb_write && wb_adr_i == reg_addr_t'(`REG_ADDR_INVALID)) begin
                clr_q <= link_mask_t'(wb_dat_i);
            end else begin
                clr_q <= '0;
            end
        end
    end

    // Read data captured with the ack
    always_ff @(posedge ps_clk) begin
        if (wb_access) begin
            dat_q <= rd_data;
        end
    end

    assign wb_ack_o      = ack_q;
    assign wb_dat_o      = dat_q;
    assign bridge_sel_o  = bridge_sel_q;
    assign invalid_clr_o = clr_q;

    // Master still holds the request in the ack cycle
    ack_needs_req: assert property (
        @(posedge ps_clk) disable iff (!rst_n_i)
        wb_ack_o |-> (wb_cyc_i && wb_stb_i)
    ) else $error("ack raised without a request");

endmodule

// ==== testbench/turf_ctrl_checker.sv ====
`timescale 1ns/100ps
`include "turf_defs.svh"

module turf_ctrl_checker (
    input  logic        ps_clk,
    input  logic        rst_n_i,
    // Expected values from the stimulus table
    input  logic [1:0]  exp_kind_i,
    input  logic [31:0] exp_val_i,
    input  int          test_id_i,
    input  logic        i2c_on_i,
    // Watched DUT inputs
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic [3:0]  wb_adr_i,
    input  logic        crate_stb_i,
    input  logic [1:0]  crate_link_i,
    input  logic        ps_scl_i,
    input  logic        ps_sda_t_i,
    input  logic        clk_sda_i,
    input  logic        cal_sda_i,
    // Watched DUT outputs
    input  logic        wb_ack_i,
    input  logic [31:0] wb_rdat_i,
    input  logic        crate_fwd_i,
    input  logic [1:0]  crate_fwd_link_i,
    input  logic        clk_scl_out_i,
    input  logic        cal_scl_out_i,
    input  logic        clk_oe_i,
    input  logic        cal_oe_i,
    input  logic        ps_sda_out_i,
    input  logic        hsk_tick_i,
    input  logic        gps_tick_i,
    // Results
    output int          pass_cnt_o,
    output int          fail_cnt_o,
    output logic        ticks_done_o
);

    localparam logic [1:0] K_RD = 2'd0;
    localparam logic [1:0] K_WR = 2'd1;
    // Tick windows and counts, N*ADD/2^BITS
    localparam int HSK_N   = 1 << `HSK_BAUD_BITS;
    localparam int GPS_N   = 1 << `GPS_BAUD_BITS;
    localparam int HSK_EXP = (HSK_N * `HSK_BAUD_ADD) >> `HSK_BAUD_BITS;
    localparam int GPS_EXP = (GPS_N * `GPS_BAUD_ADD) >> `GPS_BAUD_BITS;

    int         bus_pass = 0;
    int         bus_fail = 0;
    int         ack_wait = 0;
    // Crate strobe seen last cycle
    logic       pend = 1'b0;
    logic       pend_exp = 1'b0;
    logic [1:0] pend_link = 2'd0;
    int         pend_id = 0;
    // I2C state, bus idles high
    int         i2c_errs = 0;
    logic       i2c_was_on = 1'b0;
    logic       sda_h1 = 1'b1;
    logic       sda_h2 = 1'b1;
    // Tick counting
    int         tick_pass = 0;
    int         tick_fail = 0;
    int         cyc = 0;
    int         hsk_cnt = 0;
    int         gps_cnt = 0;
    logic       hsk_prev = 1'b0;
    logic       gps_prev = 1'b0;
    logic       done_q = 1'b0;

    function automatic bit tick_result(input string name, input int cnt, input int exp_cnt,
                                       input int n);
        if (cnt != exp_cnt) begin
            $display("Fail @ %0t: %s ticks %0d in %0d cycles, expected %0d",
                     $time, name, cnt, n, exp_cnt);
            return 1'b0;
        end
        $display("test %s ticks: %0d in %0d cycles ok", name, cnt, n);
        return 1'b1;
    endfunction

    //////////////////////////////////////////////////
    // Register port, crate forward, I2C pins
    //////////////////////////////////////////////////

    always @(posedge ps_clk) begin
        // Ack due exactly one cycle after the request
        if (wb_ack_i) begin
            if (!(wb_cyc_i && wb_stb_i) || ack_wait != 1) begin
                $display("Fail @ %0t: test %0d ack after %0d cycles", $time, test_id_i, ack_wait);
                bus_fail++;
            end else if (exp_kind_i == K_RD && wb_rdat_i !== exp_val_i) begin
                $display("Fail @ %0t: test %0d read adr %0d got %h expected %h",
                         $time, test_id_i, wb_adr_i, wb_rdat_i, exp_val_i);
                bus_fail++;
            end else begin
                $display("test %0d: %s adr %0d ok", test_id_i,
                         (exp_kind_i == K_WR) ? "write" : "read", wb_adr_i);
                bus_pass++;
            end
            ack_wait = 0;
        end else if (wb_cyc_i && wb_stb_i) begin
            ack_wait++;
        end

        // Forward due one cycle after the strobe
        if (pend) begin
            if (crate_fwd_i !== pend_exp || (pend_exp && crate_fwd_link_i !== pend_link)) begin
                $display("Fail @ %0t: test %0d crate link %0d fwd %b link %0d, expected fwd %b",
                         $time, pend_id, pend_link, crate_fwd_i, crate_fwd_link_i, pend_exp);
                bus_fail++;
            end else begin
                $display("test %0d: crate link %0d %s ok", pend_id, pend_link,
                         pend_exp ? "forwarded" : "refused");
                bus_pass++;
            end
        end else if (crate_fwd_i) begin
            $display("Fail @ %0t: crate forward without a crate access", $time);
            bus_fail++;
        end
        pend      <= crate_stb_i;
        pend_exp  <= exp_val_i[0];
        pend_link <= crate_link_i;
        pend_id   <= test_id_i;

        // SDA return lags the bus inputs by two samples
        if (i2c_on_i) begin
            if (clk_scl_out_i !== ps_scl_i || cal_scl_out_i !== ps_scl_i ||
                clk_oe_i !== ~ps_sda_t_i || cal_oe_i !== ~ps_sda_t_i ||
                ps_sda_out_i !== sda_h2) begin
                $display("Fail @ %0t: I2C scl %b/%b oe %b/%b sda %b, expected %b %b %b",
                         $time, clk_scl_out_i, cal_scl_out_i, clk_oe_i, cal_oe_i,
                         ps_sda_out_i, ps_scl_i, ~ps_sda_t_i, sda_h2);
                i2c_errs++;
            end
        end else if (i2c_was_on) begin
            if (i2c_errs == 0) begin
                $display("test i2c: merging ok");
                bus_pass++;
            end else begin
                $display("test i2c: %0d pin mismatches", i2c_errs);
                bus_fail++;
            end
        end
        i2c_was_on <= i2c_on_i;
        sda_h2     <= sda_h1;
        sda_h1     <= clk_sda_i & cal_sda_i;
    end

    //////////////////////////////////////////////////
    // Baud ticks
    //////////////////////////////////////////////////

    always @(posedge ps_clk) begin
        if (rst_n_i) begin
            cyc++;
            // Sample k+1 shows the tick of edge k
            if (hsk_tick_i && cyc >= 2 && cyc <= HSK_N + 1) begin
                hsk_cnt++;
            end
            if (gps_tick_i && cyc >= 2 && cyc <= GPS_N + 1) begin
                gps_cnt++;
            end
            if ((hsk_tick_i && hsk_prev) || (gps_tick_i && gps_prev)) begin
                $display("Fail @ %0t: baud tick longer than one cycle", $time);
                tick_fail++;
            end
            if (cyc == HSK_N + 1) begin
                if (tick_result("hsk", hsk_cnt, HSK_EXP, HSK_N)) begin
                    tick_pass++;
                end else begin
                    tick_fail++;
                end
            end
            if (cyc == GPS_N + 1) begin
                if (tick_result("gps", gps_cnt, GPS_EXP, GPS_N)) begin
                    tick_pass++;
                end else begin
                    tick_fail++;
                end
                done_q <= 1'b1;
            end
        end
        hsk_prev <= hsk_tick_i;
        gps_prev <= gps_tick_i;
    end

    assign pass_cnt_o   = bus_pass + tick_pass;
    assign fail_cnt_o   = bus_fail + tick_fail;
    assign ticks_done_o = done_q;

endmodule

// ==== testbench/turf_ctrl_tb.sv ====
`timescale 1ns/100ps

module turf_ctrl_tb;

    localparam logic [1:0] K_RD    = 2'd0;
    localparam logic [1:0] K_WR    = 2'd1;
    localparam logic [1:0] K_CRATE = 2'd2;
    localparam int NUM_ENTRIES  = 16;
    localparam int I2C_PATTERNS = 40;
    localparam int ACK_TIMEOUT  = 8;

    // Kind, address or link, write data or link-up levels, expected value
    typedef struct packed {
        logic [1:0]  kind;
        logic [3:0]  arg;
        logic [31:0] data;
        logic [31:0] exp_val;
    } entry_t;

    entry_t      stim [NUM_ENTRIES];
    integer      seed;
    int          timeouts;

    logic        ps_clk;
    logic        rst_n_i;
    logic        wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
    logic [3:0]  wb_adr_i, aurora_up_i;
    logic [31:0] wb_dat_i, wb_dat_o;
    logic        crate_stb_i, crate_fwd_o;
    logic [1:0]  crate_link_i, crate_fwd_link_o;
    logic        ps_scl_i, ps_sda_t_i, ps_sda_o, clk_sda_i, cal_sda_i;
    logic        clk_scl_o, clk_sda_oe_o, cal_scl_o, cal_sda_oe_o;
    logic        hsk_tick_o, gps_tick_o;
    // Checker side
    logic [1:0]  exp_kind_i;
    logic [31:0] exp_val_i;
    int          test_id_i;
    logic        i2c_on_i;
    int          pass_cnt_o, fail_cnt_o;
    logic        ticks_done_o;

    turf_ctrl_top dut0 (.*);

    turf_ctrl_checker chk0 (
        .*,
        .wb_ack_i         (wb_ack_o),
        .wb_rdat_i        (wb_dat_o),
        .crate_fwd_i      (crate_fwd_o),
        .crate_fwd_link_i (crate_fwd_link_o),
        .clk_scl_out_i    (clk_scl_o),
        .cal_scl_out_i    (cal_scl_o),
        .clk_oe_i         (clk_sda_oe_o),
        .cal_oe_i         (cal_sda_oe_o),
        .ps_sda_out_i     (ps_sda_o),
        .hsk_tick_i       (hsk_tick_o),
        .gps_tick_i       (gps_tick_o)
    );

    initial begin
        ps_clk = 1'b0;
        forever #2 ps_clk = ~ps_clk;
    end

    // Holds the request until ack, then drops it
    task automatic reg_access(input logic we, input logic [3:0] adr, input logic [31:0] dat);
        int waited;
        waited   = 0;
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= we;
        wb_adr_i <= adr;
        wb_dat_i <= dat;
        do begin
            @(posedge ps_clk);
            waited++;
        end while (!wb_ack_o && waited < ACK_TIMEOUT);
        if (!wb_ack_o) begin
            $display("Test %0d got no ack within %0d cycles", test_id_i, ACK_TIMEOUT);
            timeouts++;
        end
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
    endtask

    task automatic crate_access(input logic [1:0] link, input logic [3:0] up);
        crate_stb_i  <= 1'b1;
        crate_link_i <= link;
        aurora_up_i  <= up;
        @(posedge ps_clk);
        crate_stb_i  <= 1'b0;
        // Forward or flag lands one cycle after the strobe
        @(posedge ps_clk);
    endtask

    task automatic drive_i2c_patterns();
        logic [31:0] r;
        for (int k = 0; k < I2C_PATTERNS; k++) begin
            @(posedge ps_clk);
            r = $random(seed);
            ps_scl_i   <= r[0];
            ps_sda_t_i <= r[1];
            clk_sda_i  <= r[2];
            cal_sda_i  <= r[3];
            i2c_on_i   <= 1'b1;
        end
        @(posedge ps_clk);
        // Back to an idle bus
        ps_scl_i   <= 1'b1;
        ps_sda_t_i <= 1'b1;
        clk_sda_i  <= 1'b1;
        cal_sda_i  <= 1'b1;
        i2c_on_i   <= 1'b0;
    endtask

    ////////////////////////////////////////////////
    // Stimulus table and main sequence
    ////////////////////////////////////////////////

    initial begin
        stim[0]  = '{K_RD,    4'd0, 32'h0,  32'h54555246};
        stim[1]  = '{K_RD,    4'd1, 32'h0,  32'h12340300};
        stim[2]  = '{K_RD,    4'd7, 32'h0,  32'h0};
        // Link 0 NONE, 1 AURORA, 2 RSVD2, 3 AURORA
        stim[3]  = '{K_WR,    4'd2, 32'h64, 32'h0};
        stim[4]  = '{K_RD,    4'd2, 32'h0,  32'h64};
        stim[5]  = '{K_CRATE, 4'd0, 32'h2,  32'h1};
        stim[6]  = '{K_RD,    4'd4, 32'h0,  32'h2};
        stim[7]  = '{K_CRATE, 4'd1, 32'h2,  32'h1};
        stim[8]  = '{K_CRATE, 4'd2, 32'h2,  32'h0};
        stim[9]  = '{K_CRATE, 4'd3, 32'h2,  32'h0};
        stim[10] = '{K_RD,    4'd3, 32'h0,  32'hc};
        // Clear link 2 only
        stim[11] = '{K_WR,    4'd3, 32'h4,  32'h0};
        stim[12] = '{K_RD,    4'd3, 32'h0,  32'h8};
        stim[13] = '{K_CRATE, 4'd2, 32'h2,  32'h0};
        stim[14] = '{K_RD,    4'd3, 32'h0,  32'hc};
        // Link 3 up now, so it forwards
        stim[15] = '{K_CRATE, 4'd3, 32'ha,  32'h1};

        seed         = 32'habf440a1;
        timeouts     = 0;
        rst_n_i      = 1'b0;
        wb_cyc_i     = 1'b0;
        wb_stb_i     = 1'b0;
        wb_we_i      = 1'b0;
        wb_adr_i     = 4'd0;
        wb_dat_i     = 32'd0;
        aurora_up_i  = 4'd0;
        crate_stb_i  = 1'b0;
        crate_link_i = 2'd0;
        ps_scl_i     = 1'b1;
        ps_sda_t_i   = 1'b1;
        clk_sda_i    = 1'b1;
        cal_sda_i    = 1'b1;
        exp_kind_i   = K_RD;
        exp_val_i    = 32'd0;
        test_id_i    = 0;
        i2c_on_i     = 1'b0;

        repeat (3) @(posedge ps_clk);
        rst_n_i <= 1'b1;

        foreach (stim[i]) begin
            @(posedge ps_clk);
            test_id_i  <= i;
            exp_kind_i <= stim[i].kind;
            exp_val_i  <= stim[i].exp_val;
            if (stim[i].kind == K_CRATE) begin
                crate_access(stim[i].arg[1:0], stim[i].data[3:0]);
            end else begin
                reg_access(stim[i].kind == K_WR, stim[i].arg, stim[i].data);
            end
        end

        drive_i2c_patterns();

        // Tick windows run from reset, the watchdog bounds this wait
        while (!ticks_done_o) begin
            @(posedge ps_clk);
        end
        @(posedge ps_clk);
        $display("Tests passed %0d, failed %0d, ack timeouts %0d",
                 pass_cnt_o, fail_cnt_o, timeouts);
        if (fail_cnt_o == 0 && timeouts == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Table budget plus the longest tick window
    initial begin
        repeat (NUM_ENTRIES * 8 + 4096 + 100) @(posedge ps_clk);
        $display("Watchdog expired before the tests finished");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== turf_ctrl.f ====
+incdir+source
source/turf_pkg.sv
source/turf_regfile.sv
source/bridge_check.sv
source/i2c_merger.sv
source/baud_tick_gen.sv
source/turf_ctrl_top.sv
testbench/turf_ctrl_checker.sv
testbench/turf_ctrl_tb.sv
